//--- common/core_pkg.sv
/* Shared definitions for the accumulator execution core
   Data widths, kept opcodes, decode fields, ALU control and status types */
package core_pkg;

        typedef logic [7:0] byte_t;
        typedef logic [4:0] op_group_t;
        typedef logic [2:0] addr_mode_t;

        // Kept opcodes, immediate or implied only
        localparam byte_t OPC_ORA_IMM = 8'h09;
        localparam byte_t OPC_AND_IMM = 8'h29;
        localparam byte_t OPC_EOR_IMM = 8'h49;
        localparam byte_t OPC_ADC_IMM = 8'h69;
        localparam byte_t OPC_SBC_IMM = 8'hE9;
        localparam byte_t OPC_CMP_IMM = 8'hC9;
        localparam byte_t OPC_LDA_IMM = 8'hA9;
        localparam byte_t OPC_LDX_IMM = 8'hA2;
        localparam byte_t OPC_LDY_IMM = 8'hA0;
        localparam byte_t OPC_CPX_IMM = 8'hE0;
        localparam byte_t OPC_CPY_IMM = 8'hC0;
        localparam byte_t OPC_INX     = 8'hE8;
        localparam byte_t OPC_INY     = 8'hC8;
        localparam byte_t OPC_DEX     = 8'hCA;
        localparam byte_t OPC_DEY     = 8'h88;

        // Operation group is {opcode[7:5], opcode[1:0]}
        localparam op_group_t GROUP_ORA = 5'b000_01;
        localparam op_group_t GROUP_AND = 5'b001_01;
        localparam op_group_t GROUP_EOR = 5'b010_01;
        localparam op_group_t GROUP_ADC = 5'b011_01;
        localparam op_group_t GROUP_LDA = 5'b101_01;
        localparam op_group_t GROUP_CMP = 5'b110_01;
        localparam op_group_t GROUP_SBC = 5'b111_01;
        localparam op_group_t GROUP_LDY = 5'b101_00;
        localparam op_group_t GROUP_LDX = 5'b101_10;
        // INY and INX share these groups with the compares
        localparam op_group_t GROUP_CPY = 5'b110_00;
        localparam op_group_t GROUP_CPX = 5'b111_00;
        localparam op_group_t GROUP_DEX = 5'b110_10;
        localparam op_group_t GROUP_DEY = 5'b100_00;

        // Addressing mode is opcode[4:2]
        localparam addr_mode_t AM_IMM_GROUP0 = 3'b000;
        localparam addr_mode_t AM_IMM_GROUP1 = 3'b010;
        localparam addr_mode_t AM_IMPLIED    = 3'b010;

        typedef enum logic [2:0] {OP_OR, OP_AND, OP_XOR, OP_SUM, OP_PASS_B} alu_op_e;

        typedef enum logic [2:0] {SRC_A, SRC_X, SRC_Y, SRC_IMM, SRC_ZERO, SRC_FF} src_e;

        typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_FLAG} carry_sel_e;

        typedef enum logic [1:0] {DEST_NONE, DEST_A, DEST_X, DEST_Y} dest_e;

        typedef enum logic [1:0] {ST_IDLE, ST_EXECUTE, ST_WRITEBACK} ctrl_state_e;

        typedef struct packed {
                logic upd_nz;
                logic upd_c;
                logic upd_v;
        } flag_update_t;

        typedef struct packed {
                alu_op_e    op;
                src_e       src_a;
                src_e       src_b;
                logic       invert_b;
                carry_sel_e carry_sel;
                byte_t      imm;
        } alu_ctrl_t;

        typedef struct packed {
                byte_t value;
                logic  carry;
                logic  overflow;
        } alu_result_t;

        typedef struct packed {
                logic n;
                logic v;
                logic z;
                logic c;
        } status_t;

endpackage

//--- control/instr_control.sv
/* Instruction controller: idle, execute and writeback sequencing
   with opcode decode into ALU, destination and flag controls */
`timescale 1ns/100ps

module instr_control (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  instruction_ready,
        input  core_pkg::byte_t       opcode,
        input  core_pkg::byte_t       operand,
        output core_pkg::alu_ctrl_t   alu_ctrl,
        output core_pkg::dest_e       dest,
        output logic                  reg_write,
        output core_pkg::flag_update_t flag_update,
        output logic                  flag_write,
        output logic                  instruction_done
);

        core_pkg::ctrl_state_e state;
        core_pkg::byte_t       opcode_q;
        core_pkg::byte_t       operand_q;
        core_pkg::op_group_t   group;
        core_pkg::addr_mode_t  mode;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state            <= core_pkg::ST_IDLE;
                        instruction_done <= 1'b0;
                end else begin
                        instruction_done <= 1'b0;
                        case (state)
                                core_pkg::ST_IDLE: begin
                                        if (instruction_ready)
                                                state <= core_pkg::ST_EXECUTE;
                                end
                                core_pkg::ST_EXECUTE: state <= core_pkg::ST_WRITEBACK;
                                default: begin
                                        state            <= core_pkg::ST_IDLE;
                                        instruction_done <= 1'b1;
                                end
                        endcase
                end
        end

        // Instruction latch, held until the next accepted strobe
        always_ff @(posedge clk) begin
                if (state == core_pkg::ST_IDLE && instruction_ready) begin
                        opcode_q  <= opcode;
                        operand_q <= operand;
                end
        end

        assign group      = {opcode_q[7:5], opcode_q[1:0]};
        assign mode       = opcode_q[4:2];
        assign reg_write  = (state == core_pkg::ST_WRITEBACK);
        assign flag_write = (state == core_pkg::ST_WRITEBACK);

        always_comb begin
                alu_ctrl.op        = core_pkg::OP_PASS_B;
                alu_ctrl.src_a     = core_pkg::SRC_A;
                alu_ctrl.src_b     = core_pkg::SRC_IMM;
                alu_ctrl.invert_b  = 1'b0;
                alu_ctrl.carry_sel = core_pkg::CIN_ZERO;
                alu_ctrl.imm       = operand_q;
                dest               = core_pkg::DEST_NONE;
                flag_update        = '0;

                case (group)
                        core_pkg::GROUP_ORA, core_pkg::GROUP_AND, core_pkg::GROUP_EOR,
                        core_pkg::GROUP_ADC, core_pkg::GROUP_SBC, core_pkg::GROUP_CMP,
                        core_pkg::GROUP_LDA: begin
                                if (mode == core_pkg::AM_IMM_GROUP1) begin
                                        dest               = core_pkg::DEST_A;
                                        flag_update.upd_nz = 1'b1;
                                        case (group)
                                                core_pkg::GROUP_ORA: alu_ctrl.op = core_pkg::OP_OR;
                                                core_pkg::GROUP_AND: alu_ctrl.op = core_pkg::OP_AND;
                                                core_pkg::GROUP_EOR: alu_ctrl.op = core_pkg::OP_XOR;
                                                core_pkg::GROUP_LDA: alu_ctrl.op = core_pkg::OP_PASS_B;
                                                core_pkg::GROUP_CMP: begin
                                                        alu_ctrl.op        = core_pkg::OP_SUM;
                                                        alu_ctrl.invert_b  = 1'b1;
                                                        alu_ctrl.carry_sel = core_pkg::CIN_ONE;
                                                        dest               = core_pkg::DEST_NONE;
                                                        flag_update.upd_c  = 1'b1;
                                                end
                                                default: begin
                                                        // ADC, and SBC as A + ~imm + C
                                                        alu_ctrl.op        = core_pkg::OP_SUM;
                                                        alu_ctrl.invert_b  = (group == core_pkg::GROUP_SBC);
                                                        alu_ctrl.carry_sel = core_pkg::CIN_FLAG;
                                                        flag_update.upd_c  = 1'b1;
                                                        flag_update.upd_v  = 1'b1;
                                                end
                                        endcase
                                end
                        end
                        core_pkg::GROUP_LDX, core_pkg::GROUP_LDY: begin
                                if (mode == core_pkg::AM_IMM_GROUP0) begin
                                        dest = (group == core_pkg::GROUP_LDX) ? core_pkg::DEST_X
                                                                              : core_pkg::DEST_Y;
                                        flag_update.upd_nz = 1'b1;
                                end
                        end
                        core_pkg::GROUP_CPX, core_pkg::GROUP_CPY: begin
                                alu_ctrl.op    = core_pkg::OP_SUM;
                                alu_ctrl.src_a = (group == core_pkg::GROUP_CPX) ? core_pkg::SRC_X
                                                                                : core_pkg::SRC_Y;
                                if (mode == core_pkg::AM_IMM_GROUP0) begin
                                        alu_ctrl.invert_b  = 1'b1;
                                        alu_ctrl.carry_sel = core_pkg::CIN_ONE;
                                        flag_update.upd_nz = 1'b1;
                                        flag_update.upd_c  = 1'b1;
                                end else if (mode == core_pkg::AM_IMPLIED) begin
                                        // INX and INY
                                        alu_ctrl.src_b     = core_pkg::SRC_ZERO;
                                        alu_ctrl.carry_sel = core_pkg::CIN_ONE;
                                        dest = (group == core_pkg::GROUP_CPX) ? core_pkg::DEST_X
                                                                              : core_pkg::DEST_Y;
                                        flag_update.upd_nz = 1'b1;
                                end
                        end
                        core_pkg::GROUP_DEX, core_pkg::GROUP_DEY: begin
                                if (mode == core_pkg::AM_IMPLIED) begin
                                        alu_ctrl.op    = core_pkg::OP_SUM;
                                        alu_ctrl.src_b = core_pkg::SRC_FF;
                                        if (group == core_pkg::GROUP_DEX) begin
                                                alu_ctrl.src_a = core_pkg::SRC_X;
                                                dest           = core_pkg::DEST_X;
                                        end else begin
                                                alu_ctrl.src_a = core_pkg::SRC_Y;
                                                dest           = core_pkg::DEST_Y;
                                        end
                                        flag_update.upd_nz = 1'b1;
                                end
                        end
                        default: ;
                endcase
        end

endmodule

//--- rtl/alu.sv
/* ALU with operand and carry selection, logic ops, 8-bit add
   with carry-out and signed overflow, and a registered result */
`timescale 1ns/100ps

module alu (
        input  logic                  clk,
        input  logic                  reset_n,
        input  core_pkg::alu_ctrl_t   alu_ctrl,
        input  core_pkg::byte_t       a,
        input  core_pkg::byte_t       x,
        input  core_pkg::byte_t       y,
        input  logic                  carry_flag,
        output core_pkg::alu_result_t alu_result
);

        core_pkg::byte_t       op_a;
        core_pkg::byte_t       op_b;
        logic                  carry_in;
        logic [8:0]            sum;
        core_pkg::alu_result_t result_d;

        function automatic core_pkg::byte_t pick(input core_pkg::src_e sel);
                case (sel)
                        core_pkg::SRC_A:    return a;
                        core_pkg::SRC_X:    return x;
                        core_pkg::SRC_Y:    return y;
                        core_pkg::SRC_IMM:  return alu_ctrl.imm;
                        core_pkg::SRC_FF:   return 8'hFF;
                        default:            return 8'h00;
                endcase
        endfunction

        always_comb begin
                op_a = pick(alu_ctrl.src_a);
                op_b = pick(alu_ctrl.src_b);
                // Subtract and compare add the inverted operand
                if (alu_ctrl.invert_b)
                        op_b = ~op_b;
        end

        always_comb begin
                case (alu_ctrl.carry_sel)
                        core_pkg::CIN_ONE:  carry_in = 1'b1;
                        core_pkg::CIN_FLAG: carry_in = carry_flag;
                        default:            carry_in = 1'b0;
                endcase
        end

        assign sum = {1'b0, op_a} + {1'b0, op_b} + {8'h00, carry_in};

        always_comb begin
                result_d.carry    = 1'b0;
                result_d.overflow = 1'b0;
                case (alu_ctrl.op)
                        core_pkg::OP_OR:  result_d.value = op_a | op_b;
                        core_pkg::OP_AND: result_d.value = op_a & op_b;
                        core_pkg::OP_XOR: result_d.value = op_a ^ op_b;
                        core_pkg::OP_SUM: begin
                                result_d.value    = sum[7:0];
                                result_d.carry    = sum[8];
                                // Same-sign operands giving an opposite-sign sum
                                result_d.overflow = (op_a[7] == op_b[7]) && (sum[7] != op_a[7]);
                        end
                        default:          result_d.value = op_b;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n)
                        alu_result <= '0;
                else
                        alu_result <= result_d;
        end

endmodule

//--- rtl/register_file.sv
/* Architectural A, X and Y registers, written from the ALU result */
`timescale 1ns/100ps

module register_file (
        input  logic                  clk,
        input  logic                  reset_n,
        input  core_pkg::dest_e       dest,
        input  logic                  reg_write,
        input  core_pkg::alu_result_t alu_result,
        output core_pkg::byte_t       a,
        output core_pkg::byte_t       x,
        output core_pkg::byte_t       y
);

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        a <= '0;
                        x <= '0;
                        y <= '0;
                end else if (reg_write) begin
                        case (dest)
                                core_pkg::DEST_A: a <= alu_result.value;
                                core_pkg::DEST_X: x <= alu_result.value;
                                core_pkg::DEST_Y: y <= alu_result.value;
                                // Compares and unknown opcodes write nothing
                                default: ;
                        endcase
                end
        end

endmodule

//--- rtl/status_flags.sv
/* N, V, Z and C status register with per-group update mask */
`timescale 1ns/100ps

module status_flags (
        input  logic                   clk,
        input  logic                   reset_n,
        input  core_pkg::flag_update_t flag_update,
        input  logic                   flag_write,
        input  core_pkg::alu_result_t  alu_result,
        output core_pkg::status_t      status
);

        logic neg;
        logic zero;

        assign neg  = alu_result.value[7];
        assign zero = (alu_result.value == 8'h00);

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        status <= '0;
                end else if (flag_write) begin
                        if (flag_update.upd_nz) begin
                                status.n <= neg;
                                status.z <= zero;
                        end
                        if (flag_update.upd_c)
                                status.c <= alu_result.carry;
                        if (flag_update.upd_v)
                                status.v <= alu_result.overflow;
                end
        end

endmodule

//--- rtl/exec_core.sv
/* Execution core top: controller, ALU, register file and flags */
`timescale 1ns/100ps

module exec_core (
        input  logic              clk,
        input  logic              reset_n,
        input  logic              instruction_ready,
        input  core_pkg::byte_t   opcode,
        input  core_pkg::byte_t   operand,
        output logic              instruction_done,
        output core_pkg::byte_t   a,
        output core_pkg::byte_t   x,
        output core_pkg::byte_t   y,
        output core_pkg::status_t status
);

        core_pkg::alu_ctrl_t    alu_ctrl;
        core_pkg::dest_e        dest;
        logic                   reg_write;
        core_pkg::flag_update_t flag_update;
        logic                   flag_write;
        core_pkg::alu_result_t  alu_result;

        instr_control ctrl0 (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .opcode            (opcode),
                .operand           (operand),
                .alu_ctrl          (alu_ctrl),
                .dest              (dest),
                .reg_write         (reg_write),
                .flag_update       (flag_update),
                .flag_write        (flag_write),
                .instruction_done  (instruction_done)
        );

        alu alu0 (
                .clk        (clk),
                .reset_n    (reset_n),
                .alu_ctrl   (alu_ctrl),
                .a          (a),
                .x          (x),
                .y          (y),
                .carry_flag (status.c),
                .alu_result (alu_result)
        );

        register_file regs0 (
                .clk        (clk),
                .reset_n    (reset_n),
                .dest       (dest),
                .reg_write  (reg_write),
                .alu_result (alu_result),
                .a          (a),
                .x          (x),
                .y          (y)
        );

        status_flags flags0 (
                .clk         (clk),
                .reset_n     (reset_n),
                .flag_update (flag_update),
                .flag_write  (flag_write),
                .alu_result  (alu_result),
                .status      (status)
        );

endmodule

//--- testbench/core_model.svh
/* Reference model of the A, X and Y registers and the N, V, Z, C flags,
   stepped one instruction at a time */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

core_pkg::byte_t   model_a;
core_pkg::byte_t   model_x;
core_pkg::byte_t   model_y;
core_pkg::status_t model_flags;

task automatic clear_model();
        model_a     = 8'h00;
        model_x     = 8'h00;
        model_y     = 8'h00;
        model_flags = '0;
endtask

// Result is {overflow, carry, sum}
function automatic logic [9:0] add_bytes(input core_pkg::byte_t lhs,
                                         input core_pkg::byte_t rhs, input logic cin);
        int unsigned total;
        int          signed_total;
        total        = lhs + rhs + cin;
        // Signed result outside -128..127 is an overflow
        signed_total = $signed(lhs) + $signed(rhs) + int'(cin);
        return {(signed_total > 127) || (signed_total < -128), total > 255, total[7:0]};
endfunction

task automatic update_nz(input core_pkg::byte_t value);
        model_flags.n = value[7];
        model_flags.z = (value == 8'h00);
endtask

// Register minus imm, only N, Z and C change
task automatic compare_register(input core_pkg::byte_t value, input core_pkg::byte_t imm);
        logic [9:0] res;
        res = add_bytes(value, ~imm, 1'b1);
        update_nz(res[7:0]);
        model_flags.c = res[8];
endtask

task automatic apply_instruction(input core_pkg::byte_t op, input core_pkg::byte_t imm);
        logic [9:0]      res;
        core_pkg::byte_t addend;
        case (op)
                core_pkg::OPC_ORA_IMM: model_a = model_a | imm;
                core_pkg::OPC_AND_IMM: model_a = model_a & imm;
                core_pkg::OPC_EOR_IMM: model_a = model_a ^ imm;
                core_pkg::OPC_LDA_IMM: model_a = imm;
                core_pkg::OPC_LDX_IMM: model_x = imm;
                core_pkg::OPC_LDY_IMM: model_y = imm;
                core_pkg::OPC_INX:     model_x = model_x + 8'h01;
                core_pkg::OPC_INY:     model_y = model_y + 8'h01;
                core_pkg::OPC_DEX:     model_x = model_x + 8'hFF;
                core_pkg::OPC_DEY:     model_y = model_y + 8'hFF;
                core_pkg::OPC_ADC_IMM, core_pkg::OPC_SBC_IMM: begin
                        addend        = (op == core_pkg::OPC_SBC_IMM) ? ~imm : imm;
                        res           = add_bytes(model_a, addend, model_flags.c);
                        model_a       = res[7:0];
                        model_flags.c = res[8];
                        model_flags.v = res[9];
                end
                core_pkg::OPC_CMP_IMM: compare_register(model_a, imm);
                core_pkg::OPC_CPX_IMM: compare_register(model_x, imm);
                core_pkg::OPC_CPY_IMM: compare_register(model_y, imm);
                default: ;
        endcase
        // N and Z follow the written register
        case (op)
                core_pkg::OPC_ORA_IMM, core_pkg::OPC_AND_IMM, core_pkg::OPC_EOR_IMM,
                core_pkg::OPC_LDA_IMM, core_pkg::OPC_ADC_IMM, core_pkg::OPC_SBC_IMM:
                        update_nz(model_a);
                core_pkg::OPC_LDX_IMM, core_pkg::OPC_INX, core_pkg::OPC_DEX:
                        update_nz(model_x);
                core_pkg::OPC_LDY_IMM, core_pkg::OPC_INY, core_pkg::OPC_DEY:
                        update_nz(model_y);
                default: ;
        endcase
endtask

`endif

//--- testbench/tb_exec_core.sv
/* Testbench for the execution core: random instruction stream checked
   against a reference model, with done timing and busy strobes */
`timescale 1ns/100ps

module tb_exec_core;

        localparam int RESET_CYCLES = 16;
        localparam int NUM_INSTR    = 2000;
        // Strobe setup, strobe edge, execute and writeback
        localparam int INSTR_CYCLES = 4;
        localparam int CYCLE_LIMIT  = NUM_INSTR * INSTR_CYCLES + RESET_CYCLES + 200;
        localparam int DONE_LIMIT   = 8;

        logic              clk = 1'b0;
        logic              reset_n;
        logic              instruction_ready;
        core_pkg::byte_t   opcode;
        core_pkg::byte_t   operand;
        logic              instruction_done;
        core_pkg::byte_t   a;
        core_pkg::byte_t   x;
        core_pkg::byte_t   y;
        core_pkg::status_t status;

        integer seed         = 6525;
        int     value_errors = 0;
        int     other_errors = 0;
        int     cycle_count  = 0;

        core_pkg::byte_t kept_ops [15] = '{
                core_pkg::OPC_ORA_IMM, core_pkg::OPC_AND_IMM, core_pkg::OPC_EOR_IMM,
                core_pkg::OPC_ADC_IMM, core_pkg::OPC_SBC_IMM, core_pkg::OPC_CMP_IMM,
                core_pkg::OPC_LDA_IMM, core_pkg::OPC_LDX_IMM, core_pkg::OPC_LDY_IMM,
                core_pkg::OPC_CPX_IMM, core_pkg::OPC_CPY_IMM, core_pkg::OPC_INX,
                core_pkg::OPC_INY,     core_pkg::OPC_DEX,     core_pkg::OPC_DEY
        };

        `include "core_model.svh"

        exec_core dut0 (.*);

        always #2 clk = ~clk;

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        task automatic check_outputs();
                string exp_s;
                string got_s;
                exp_s = $sformatf("A=%02h X=%02h Y=%02h NVZC=%04b", model_a, model_x,
                                  model_y, model_flags);
                got_s = $sformatf("A=%02h X=%02h Y=%02h NVZC=%04b", a, x, y, status);
                assert ({a, x, y, status} == {model_a, model_x, model_y, model_flags}) else begin
                        $display("** Error at %0t: expected %s, got %s", $time, exp_s, got_s);
                        value_errors++;
                end
        endtask

        task automatic run_instr(input core_pkg::byte_t op, input core_pkg::byte_t imm,
                                 input logic busy);
                int   wait_cycles;
                logic done_seen;
                @(posedge clk);
                instruction_ready <= 1'b1;
                opcode            <= op;
                operand           <= imm;
                @(negedge clk);
                // Previous done pulse must already be over
                assert (instruction_done == 1'b0) else begin
                        $display("instruction_done stayed high too long at %0t", $time);
                        other_errors++;
                end
                @(posedge clk);
                if (busy) begin
                        // Strobe held into the execute cycle with a different instruction
                        opcode  <= $random(seed);
                        operand <= $random(seed);
                end else begin
                        instruction_ready <= 1'b0;
                end
                apply_instruction(op, imm);
                wait_cycles = 0;
                done_seen   = 1'b0;
                while (!done_seen && wait_cycles < DONE_LIMIT) begin
                        @(negedge clk);
                        wait_cycles++;
                        if (instruction_done) begin
                                done_seen = 1'b1;
                        end else begin
                                @(posedge clk);
                                instruction_ready <= 1'b0;
                        end
                end
                assert (done_seen) else begin
                        $display("instruction_done never rose for opcode %02h at %0t", op, $time);
                        other_errors++;
                end
                if (done_seen) begin
                        assert (wait_cycles == 3) else begin
                                $display("instruction_done came after %0d cycles instead of 3 at %0t",
                                         wait_cycles, $time);
                                other_errors++;
                        end
                        check_outputs();
                end
        endtask

        initial begin
                int unsigned     pick;
                core_pkg::byte_t op;
                core_pkg::byte_t imm;
                logic            busy;
                reset_n           <= 1'b0;
                instruction_ready <= 1'b0;
                opcode            <= 8'h00;
                operand           <= 8'h00;
                clear_model();
                repeat (RESET_CYCLES) @(posedge clk);
                reset_n <= 1'b1;
                @(negedge clk);
                assert (instruction_done == 1'b0) else begin
                        $display("instruction_done is high right after reset");
                        other_errors++;
                end
                check_outputs();

                for (int i = 0; i < NUM_INSTR; i++) begin
                        pick = $random(seed);
                        // Mostly kept opcodes, one in eight any byte
                        if (pick % 8 == 0)
                                op = $random(seed);
                        else
                                op = kept_ops[(pick >> 3) % 15];
                        imm  = $random(seed);
                        busy = (($random(seed) & 7) == 0);
                        run_instr(op, imm, busy);
                end

                $display("Errors: %0d value, %0d other", value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

//--- verilog.f
+incdir+testbench
common/core_pkg.sv
control/instr_control.sv
rtl/alu.sv
rtl/register_file.sv
rtl/status_flags.sv
rtl/exec_core.sv
testbench/tb_exec_core.sv
